// ==== hw/scalar_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, types and stage structs of the scalar core
// Referenced by scoped names from every RTL module and the testbench
//////////////////////////////////////////////////////////////////////

package scalar_pkg;

	// Widths and sizes
	localparam int DATA_W = 32;
	localparam int REG_W = 4;
	localparam int BANK_W = REG_W - 1;
	localparam int ADDR_W = 4;
	localparam int IMM_W = 16;
	localparam int NUM_REGS = 16;
	localparam int NUM_INSTR = 16;
	localparam int REGS_PER_BANK = NUM_REGS / 2;

	typedef logic [DATA_W-1:0] data_t;
	// Bit 0 selects the bank, odd or even
	typedef logic [REG_W-1:0] reg_idx_t;
	typedef logic [BANK_W-1:0] bank_idx_t;
	typedef logic [ADDR_W-1:0] addr_t;
	// Zero-extended for ADDI, target address for jumps
	typedef logic [IMM_W-1:0] imm_t;

	typedef enum logic [3:0] {
		OP_NOP = 4'h0,
		OP_ADD = 4'h1,
		OP_SUB = 4'h2,
		OP_AND = 4'h3,
		OP_OR = 4'h4,
		OP_ADDI = 4'h5,
		OP_CMP = 4'h6,
		OP_BEQ = 4'h7,
		OP_JMP = 4'h8,
		OP_MVS = 4'h9,
		OP_HALT = 4'hA
	} opcode_e;

	//////////////////////////////////////////////////////////////////////
	// Stage structs
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opcode_e opcode;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		imm_t imm;
	} instr_t;

	// Issue to operand read
	typedef struct packed {
		logic valid;
		instr_t instr;
	} issue_t;

	// Operand read to execution
	typedef struct packed {
		logic valid;
		instr_t instr;
		data_t data1;
		data_t data2;
	} operand_t;

	// Write-back to register banks and scoreboard
	typedef struct packed {
		logic valid;
		reg_idx_t dst;
		data_t data;
	} wb_t;

	// Opcodes with a register result
	function automatic logic writes_reg(input opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI};
	endfunction

endpackage

// ==== hw/instr_mem.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction memory, filled through the store strobe while idle
// and read one cycle after each fetch strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_mem (
	input	logic					clock,
	input	logic					reset,
	input	logic					en,
	input	logic					req_st,
	input	scalar_pkg::instr_t		st_instr,
	output	logic					ack_st,
	input	logic					fetch,
	input	scalar_pkg::addr_t		fetch_addr,
	output	scalar_pkg::instr_t		fetch_instr
);

	scalar_pkg::instr_t		mem [scalar_pkg::NUM_INSTR];
	scalar_pkg::addr_t		st_ptr;
	logic					store;

	// Loading only while the core is not running
	assign store = req_st & ~en;

	always_ff @(posedge clock) begin
		if (reset) begin
			st_ptr <= '0;
			ack_st <= 1'b0;
		end else begin
			ack_st <= store;
			if (store) begin
				st_ptr <= st_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (store) begin
			mem[st_ptr] <= st_instr;
		end
		// Output holds between fetches
		if (fetch) begin
			fetch_instr <= mem[fetch_addr];
		end
	end

endmodule

// ==== hw/program_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Program counter and fetch control, waits on each jump or branch
// until the execution stage resolves it, stops for good on HALT
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module program_ctrl (
	input	logic					clock,
	input	logic					reset,
	input	logic					en,
	input	logic					stall,
	input	scalar_pkg::instr_t		fetch_instr,
	input	logic					redirect,
	input	logic					resolved,
	input	scalar_pkg::addr_t		target,
	output	logic					fetch,
	output	scalar_pkg::addr_t		fetch_addr
);

	typedef enum logic [1:0] {
		FETCH,
		WAIT_BRANCH,
		HALTED
	} run_state_e;

	run_state_e				state;
	scalar_pkg::addr_t		pc;
	logic					ret_valid;
	logic					ctrl_ret;

	// Fresh word from memory that changes the flow
	assign ctrl_ret = ret_valid & (fetch_instr.opcode inside
		{scalar_pkg::OP_BEQ, scalar_pkg::OP_JMP, scalar_pkg::OP_HALT});

	assign fetch = en & (state == FETCH) & ~stall & ~ctrl_ret;
	assign fetch_addr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
			pc <= '0;
			ret_valid <= 1'b0;
		end else if (en) begin
			ret_valid <= fetch;
			if (fetch) begin
				pc <= pc + 1'b1;
			end
			case (state)
				FETCH: begin
					if (ctrl_ret) begin
						state <= (fetch_instr.opcode == scalar_pkg::OP_HALT) ? HALTED : WAIT_BRANCH;
					end
				end
				WAIT_BRANCH: begin
					// PC already points at the fall-through word
					if (resolved) begin
						state <= FETCH;
						if (redirect) begin
							pc <= target;
						end
					end
				end
				default: begin
					state <= HALTED;
				end
			endcase
		end
	end

endmodule

// ==== hw/hazard_check.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch register and register scoreboard; issues one instruction
// per cycle when its sources and destination have no write pending
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hazard_check (
	input	logic					clock,
	input	logic					reset,
	input	logic					en,
	input	logic					fetch_valid,
	input	scalar_pkg::instr_t		fetch_instr,
	input	scalar_pkg::wb_t		wb,
	output	logic					stall,
	output	scalar_pkg::issue_t		issue
);

	scalar_pkg::issue_t					fetch_q;
	scalar_pkg::instr_t					cur;
	logic								pend;
	logic [scalar_pkg::NUM_REGS-1:0]	busy;
	logic								use_src1;
	logic								use_src2;
	logic								use_dst;
	logic								hazard;
	logic								go;

	assign cur = fetch_q.instr;

	// Register usage per opcode
	assign use_src1 = cur.opcode inside {scalar_pkg::OP_ADD, scalar_pkg::OP_SUB,
		scalar_pkg::OP_AND, scalar_pkg::OP_OR, scalar_pkg::OP_ADDI,
		scalar_pkg::OP_CMP, scalar_pkg::OP_MVS};
	assign use_src2 = cur.opcode inside {scalar_pkg::OP_ADD, scalar_pkg::OP_SUB,
		scalar_pkg::OP_AND, scalar_pkg::OP_OR, scalar_pkg::OP_CMP};
	assign use_dst = scalar_pkg::writes_reg(cur.opcode);

	// RAW on sources, WAW on destination
	assign hazard = (use_src1 & busy[cur.src1]) | (use_src2 & busy[cur.src2]) |
		(use_dst & busy[cur.dst]);

	assign stall = fetch_q.valid & hazard;
	assign go = en & fetch_q.valid & ~hazard;

	always_ff @(posedge clock) begin
		if (reset) begin
			pend <= 1'b0;
			fetch_q.valid <= 1'b0;
			issue.valid <= 1'b0;
			busy <= '0;
		end else begin
			if (en) begin
				// Memory output waits while the fetch register is stuck
				pend <= fetch_valid | (pend & stall);
				if (~stall) begin
					fetch_q.valid <= pend;
					fetch_q.instr <= fetch_instr;
				end
				issue.valid <= go;
				issue.instr <= cur;
			end
			if (wb.valid) begin
				busy[wb.dst] <= 1'b0;
			end
			if (go & use_dst) begin
				busy[cur.dst] <= 1'b1;
			end
		end
	end

endmodule

// ==== hw/reg_file.sv ====
//////////////////////////////////////////////////////////////////////
// One register bank, one write port and two combinational reads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_file (
	input	logic					clock,
	input	logic					reset,
	input	logic					we,
	input	scalar_pkg::bank_idx_t	wr_idx,
	input	scalar_pkg::data_t		wr_data,
	input	scalar_pkg::bank_idx_t	rd_idx1,
	input	scalar_pkg::bank_idx_t	rd_idx2,
	output	scalar_pkg::data_t		rd_data1,
	output	scalar_pkg::data_t		rd_data2
);

	scalar_pkg::data_t		regs [scalar_pkg::REGS_PER_BANK];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < scalar_pkg::REGS_PER_BANK; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_data1 = regs[rd_idx1];
	assign rd_data2 = regs[rd_idx2];

endmodule

// ==== hw/operand_read.sv ====
//////////////////////////////////////////////////////////////////////
// Operand read over the even and odd banks; register index bit 0
// picks the bank, the result is registered one cycle after issue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module operand_read (
	input	logic					clock,
	input	logic					reset,
	input	logic					en,
	input	scalar_pkg::issue_t		issue,
	input	scalar_pkg::wb_t		wb,
	output	scalar_pkg::operand_t	operand
);

	scalar_pkg::reg_idx_t		src1;
	scalar_pkg::reg_idx_t		src2;
	logic						odd1;
	logic						odd2;
	scalar_pkg::bank_idx_t		even_idx1;
	scalar_pkg::bank_idx_t		odd_idx1;
	scalar_pkg::data_t			even_data1;
	scalar_pkg::data_t			even_data2;
	scalar_pkg::data_t			odd_data1;
	scalar_pkg::data_t			odd_data2;
	scalar_pkg::data_t			data1;
	scalar_pkg::data_t			data2;

	assign src1 = issue.instr.src1;
	assign src2 = issue.instr.src2;
	assign odd1 = src1[0];
	assign odd2 = src2[0];

	// Port 1 serves src1 in its own bank and src2 in the other one
	assign even_idx1 = odd1 ? src2[scalar_pkg::REG_W-1:1] : src1[scalar_pkg::REG_W-1:1];
	assign odd_idx1 = odd1 ? src1[scalar_pkg::REG_W-1:1] : src2[scalar_pkg::REG_W-1:1];

	reg_file bank_even (
		.clock		(clock),
		.reset		(reset),
		.we			(wb.valid & ~wb.dst[0]),
		.wr_idx		(wb.dst[scalar_pkg::REG_W-1:1]),
		.wr_data	(wb.data),
		.rd_idx1	(even_idx1),
		.rd_idx2	(src2[scalar_pkg::REG_W-1:1]),
		.rd_data1	(even_data1),
		.rd_data2	(even_data2)
	);

	reg_file bank_odd (
		.clock		(clock),
		.reset		(reset),
		.we			(wb.valid & wb.dst[0]),
		.wr_idx		(wb.dst[scalar_pkg::REG_W-1:1]),
		.wr_data	(wb.data),
		.rd_idx1	(odd_idx1),
		.rd_idx2	(src2[scalar_pkg::REG_W-1:1]),
		.rd_data1	(odd_data1),
		.rd_data2	(odd_data2)
	);

	assign data1 = odd1 ? odd_data1 : even_data1;
	// Same bank uses port 2, a split pair port 1 of the other bank
	assign data2 = (odd1 == odd2) ? (odd2 ? odd_data2 : even_data2) :
		(odd2 ? odd_data1 : even_data1);

	always_ff @(posedge clock) begin
		if (reset) begin
			operand.valid <= 1'b0;
		end else if (en) begin
			operand <= '{valid: issue.valid, instr: issue.instr, data1: data1, data2: data2};
		end
	end

endmodule

// ==== hw/exec_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Execution stage: ALU, condition register, branch resolution,
// write-back register, scalar output and the termination pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_unit (
	input	logic					clock,
	input	logic					reset,
	input	logic					en,
	input	scalar_pkg::operand_t	operand,
	output	scalar_pkg::wb_t		wb,
	output	logic					redirect,
	output	logic					resolved,
	output	scalar_pkg::addr_t		target,
	output	scalar_pkg::data_t		scalar_data,
	output	logic					term
);

	scalar_pkg::opcode_e	op;
	scalar_pkg::data_t		result;
	logic					cond;
	logic					is_branch;

	assign op = operand.instr.opcode;
	assign is_branch = (op == scalar_pkg::OP_BEQ) | (op == scalar_pkg::OP_JMP);

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (op)
			scalar_pkg::OP_ADD:		result = operand.data1 + operand.data2;
			scalar_pkg::OP_SUB:		result = operand.data1 - operand.data2;
			scalar_pkg::OP_AND:		result = operand.data1 & operand.data2;
			scalar_pkg::OP_OR:		result = operand.data1 | operand.data2;
			scalar_pkg::OP_ADDI:	result = operand.data1 + scalar_pkg::data_t'(operand.instr.imm);
			default:				result = operand.data1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Result and control registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			wb.valid <= 1'b0;
			redirect <= 1'b0;
			resolved <= 1'b0;
			cond <= 1'b0;
			scalar_data <= '0;
			term <= 1'b0;
		end else if (en) begin
			wb.valid <= operand.valid & scalar_pkg::writes_reg(op);
			wb.dst <= operand.instr.dst;
			wb.data <= result;
			// Taken when JMP, or BEQ with the condition bit set
			resolved <= operand.valid & is_branch;
			redirect <= operand.valid & ((op == scalar_pkg::OP_JMP) |
				((op == scalar_pkg::OP_BEQ) & cond));
			target <= operand.instr.imm[scalar_pkg::ADDR_W-1:0];
			if (operand.valid & (op == scalar_pkg::OP_CMP)) begin
				cond <= operand.data1 == operand.data2;
			end
			if (operand.valid & (op == scalar_pkg::OP_MVS)) begin
				scalar_data <= operand.data1;
			end
			term <= operand.valid & (op == scalar_pkg::OP_HALT);
		end else begin
			// Single pulse even if the run is paused
			term <= 1'b0;
		end
	end

endmodule

// ==== hw/scalar_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Scalar core top level: fetch, hazard check and issue, operand
// read, execution and write-back; load with en low, run with en high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scalar_unit (
	input	logic					clock,
	input	logic					reset,
	input	logic					en,
	input	logic					req_st,
	input	scalar_pkg::instr_t		st_instr,
	output	logic					ack_st,
	output	scalar_pkg::data_t		scalar_data,
	output	logic					term
);

	logic					fetch;
	scalar_pkg::addr_t		fetch_addr;
	scalar_pkg::instr_t		fetch_instr;
	logic					stall;
	logic					redirect;
	logic					resolved;
	scalar_pkg::addr_t		target;
	scalar_pkg::issue_t		issue;
	scalar_pkg::operand_t	operand;
	scalar_pkg::wb_t		wb;

	// Instruction memory
	instr_mem u_instr_mem (
		.clock			(clock),
		.reset			(reset),
		.en				(en),
		.req_st			(req_st),
		.st_instr		(st_instr),
		.ack_st			(ack_st),
		.fetch			(fetch),
		.fetch_addr		(fetch_addr),
		.fetch_instr	(fetch_instr)
	);

	// Program address control
	program_ctrl u_program_ctrl (
		.clock			(clock),
		.reset			(reset),
		.en				(en),
		.stall			(stall),
		.fetch_instr	(fetch_instr),
		.redirect		(redirect),
		.resolved		(resolved),
		.target			(target),
		.fetch			(fetch),
		.fetch_addr		(fetch_addr)
	);

	// Hazard check and issue
	hazard_check u_hazard_check (
		.clock			(clock),
		.reset			(reset),
		.en				(en),
		.fetch_valid	(fetch),
		.fetch_instr	(fetch_instr),
		.wb				(wb),
		.stall			(stall),
		.issue			(issue)
	);

	// Register read, write-back lands here too
	operand_read u_operand_read (
		.clock			(clock),
		.reset			(reset),
		.en				(en),
		.issue			(issue),
		.wb				(wb),
		.operand		(operand)
	);

	exec_unit u_exec_unit (
		.clock			(clock),
		.reset			(reset),
		.en				(en),
		.operand		(operand),
		.wb				(wb),
		.redirect		(redirect),
		.resolved		(resolved),
		.target			(target),
		.scalar_data	(scalar_data),
		.term			(term)
	);

endmodule

// ==== include/scalar_programs.svh ====
//////////////////////////////////////////////////////////////////////
// Test programs for the scalar core with their expected results
// Included inside the testbench module; words are loaded from base
//////////////////////////////////////////////////////////////////////

`ifndef SCALAR_PROGRAMS_SVH
`define SCALAR_PROGRAMS_SVH

localparam int NUM_TESTS = 5;
localparam int NUM_PROG_WORDS = 45;

// One row per program
typedef struct packed {
	logic [7:0]				base;
	logic [4:0]				len;
	scalar_pkg::data_t		exp_data;
	logic [3:0]				exp_mvs;
} test_t;

// Word layout is opcode, dst, src1, src2, imm
localparam scalar_pkg::instr_t PROG_ROM [NUM_PROG_WORDS] = '{
	// Arithmetic within the even bank
	{scalar_pkg::OP_ADDI, 4'd2, 4'd0, 4'd0, 16'd7},
	{scalar_pkg::OP_ADDI, 4'd4, 4'd0, 4'd0, 16'd12},
	{scalar_pkg::OP_ADD, 4'd6, 4'd2, 4'd4, 16'd0},
	{scalar_pkg::OP_SUB, 4'd8, 4'd4, 4'd2, 16'd0},
	{scalar_pkg::OP_AND, 4'd10, 4'd2, 4'd4, 16'd0},
	{scalar_pkg::OP_OR, 4'd12, 4'd2, 4'd4, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd6, 4'd0, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd8, 4'd0, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd12, 4'd0, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd10, 4'd0, 16'd0},
	{scalar_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0},
	// Sources split across banks
	{scalar_pkg::OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd100},
	{scalar_pkg::OP_ADDI, 4'd2, 4'd0, 4'd0, 16'd35},
	{scalar_pkg::OP_SUB, 4'd3, 4'd1, 4'd2, 16'd0},
	{scalar_pkg::OP_ADD, 4'd5, 4'd3, 4'd2, 16'd0},
	{scalar_pkg::OP_OR, 4'd7, 4'd1, 4'd3, 16'd0},
	{scalar_pkg::OP_AND, 4'd4, 4'd7, 4'd2, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd3, 4'd0, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd5, 4'd0, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd4, 4'd0, 16'd0},
	{scalar_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0},
	// Back-to-back dependence chain
	{scalar_pkg::OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd3},
	{scalar_pkg::OP_ADD, 4'd1, 4'd1, 4'd1, 16'd0},
	{scalar_pkg::OP_ADD, 4'd1, 4'd1, 4'd1, 16'd0},
	{scalar_pkg::OP_ADDI, 4'd2, 4'd1, 4'd0, 16'd5},
	{scalar_pkg::OP_SUB, 4'd3, 4'd2, 4'd1, 16'd0},
	{scalar_pkg::OP_ADD, 4'd3, 4'd3, 4'd2, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd3, 4'd0, 16'd0},
	{scalar_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0},
	// Countdown from 5, sum in r2
	{scalar_pkg::OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd5},
	{scalar_pkg::OP_ADDI, 4'd3, 4'd0, 4'd0, 16'd1},
	{scalar_pkg::OP_ADD, 4'd2, 4'd2, 4'd1, 16'd0},
	{scalar_pkg::OP_SUB, 4'd1, 4'd1, 4'd3, 16'd0},
	{scalar_pkg::OP_CMP, 4'd0, 4'd1, 4'd0, 16'd0},
	{scalar_pkg::OP_BEQ, 4'd0, 4'd0, 4'd0, 16'd7},
	{scalar_pkg::OP_JMP, 4'd0, 4'd0, 4'd0, 16'd2},
	{scalar_pkg::OP_MVS, 4'd0, 4'd1, 4'd0, 16'd0},
	{scalar_pkg::OP_MVS, 4'd0, 4'd2, 4'd0, 16'd0},
	{scalar_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0},
	// Jump over a second MVS
	{scalar_pkg::OP_ADDI, 4'd5, 4'd0, 4'd0, 16'd42},
	{scalar_pkg::OP_MVS, 4'd0, 4'd5, 4'd0, 16'd0},
	{scalar_pkg::OP_JMP, 4'd0, 4'd0, 4'd0, 16'd5},
	{scalar_pkg::OP_ADDI, 4'd5, 4'd0, 4'd0, 16'd99},
	{scalar_pkg::OP_MVS, 4'd0, 4'd5, 4'd0, 16'd0},
	{scalar_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0}
};

// base, length, last MVS value, number of MVS results
localparam test_t TESTS [NUM_TESTS] = '{
	'{8'd0, 5'd11, 32'd4, 4'd4},
	'{8'd11, 5'd10, 32'd33, 4'd3},
	'{8'd21, 5'd8, 32'd22, 4'd1},
	'{8'd29, 5'd10, 32'd15, 4'd2},
	'{8'd39, 5'd6, 32'd42, 4'd1}
};

`endif

// ==== tb/tb_scalar_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the scalar core: loads each program of the table,
// runs it to the termination pulse and checks the scalar output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_scalar_unit;

	`include "scalar_programs.svh"

	localparam int CYCLE_LIMIT = NUM_TESTS * 200;
	localparam int SETTLE_CYCLES = 10;

	logic					clock;
	logic					reset;
	logic					en;
	logic					req_st;
	scalar_pkg::instr_t		st_instr;
	logic					ack_st;
	scalar_pkg::data_t		scalar_data;
	logic					term;

	int						cycles;
	int						checks;
	int						errors;
	int						mvs_count;
	int						term_count;

	scalar_unit DUT (
		.clock			(clock),
		.reset			(reset),
		.en				(en),
		.req_st			(req_st),
		.st_instr		(st_instr),
		.ack_st			(ack_st),
		.scalar_data	(scalar_data),
		.term			(term)
	);

	always #10 clock = ~clock;

	// Run limit over all programs
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			errors++;
			$display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("tests failed");
			$finish;
		end
	end

	// MVS results and term pulses, sampled between edges
	always @(negedge clock) begin
		if (reset) begin
			mvs_count = 0;
			term_count = 0;
		end else begin
			if (en && DUT.operand.valid && DUT.operand.instr.opcode == scalar_pkg::OP_MVS) begin
				mvs_count++;
			end
			if (term) begin
				term_count++;
			end
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic reset_dut();
		@(posedge clock);
		#2;
		reset = 1'b1;
		en = 1'b0;
		req_st = 1'b0;
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;
		check_value("ack_st after reset", 32'(ack_st), 32'd0);
		check_value("term after reset", 32'(term), 32'd0);
		check_value("scalar_data after reset", scalar_data, 32'd0);
	endtask

	// One store, then ack_st high for exactly one cycle
	task automatic store_word(input scalar_pkg::instr_t word);
		req_st = 1'b1;
		st_instr = word;
		@(posedge clock);
		#2;
		req_st = 1'b0;
		check_value("ack_st after store", 32'(ack_st), 32'd1);
		@(posedge clock);
		#2;
		check_value("ack_st one cycle later", 32'(ack_st), 32'd0);
	endtask

	task automatic load_program(input int t);
		for (int i = 0; i < int'(TESTS[t].len); i++) begin
			store_word(PROG_ROM[int'(TESTS[t].base) + i]);
		end
	endtask

	task automatic run_program(input int t);
		en = 1'b1;
		while (!term) begin
			@(posedge clock);
			#2;
		end
		check_value("scalar_data at term", scalar_data, TESTS[t].exp_data);
		repeat (SETTLE_CYCLES) begin
			@(posedge clock);
			#2;
		end
		// Output holds and no second pulse follows
		check_value("scalar_data after term", scalar_data, TESTS[t].exp_data);
		check_value("term pulses", 32'(term_count), 32'd1);
		check_value("MVS results", 32'(mvs_count), 32'(TESTS[t].exp_mvs));
		en = 1'b0;
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		en = 1'b0;
		req_st = 1'b0;
		st_instr = '0;
		cycles = 0;
		checks = 0;
		errors = 0;

		for (int t = 0; t < NUM_TESTS; t++) begin
			$display("Program %0d: %0d words", t, TESTS[t].len);
			reset_dut();
			load_program(t);
			run_program(t);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
hw/scalar_pkg.sv
hw/instr_mem.sv
hw/program_ctrl.sv
hw/hazard_check.sv
hw/reg_file.sv
hw/operand_read.sv
hw/exec_unit.sv
hw/scalar_unit.sv
tb/tb_scalar_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the scalar core testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_scalar_unit \
	-o tb_scalar_unit &&
./obj_dir/tb_scalar_unit | tee /dev/stderr | grep -q "all tests passed" &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }
